//--- Bender.yml
package:
  name: mipsCtrl

sources:
  # RTL, package first
  - source/mipsCtrlPkg.sv
  - source/opcodeClassifier.sv
  - source/controlWordDecoder.sv
  - source/aluOpDecoder.sv
  - source/ctrlOutputStage.sv
  - source/mipsCtrl.sv

  # Testbench and bound assertions
  - target: test
    files:
      - testbench/mipsCtrl_assert.sv
      - testbench/mipsCtrlTb.sv

//--- mipsCtrl.f
source/mipsCtrlPkg.sv
source/opcodeClassifier.sv
source/controlWordDecoder.sv
source/aluOpDecoder.sv
source/ctrlOutputStage.sv
source/mipsCtrl.sv
testbench/mipsCtrl_assert.sv
testbench/mipsCtrlTb.sv

//--- testbench/mipsCtrl_input.txt
# instr flags ctrl aluOp valid, all hex; valid drives instrValid and is the expected ctrlValid
# flags bits: eq gz gez lz lez; ctrl is the 17-bit control word, pcSrc in the top two bits
00221820 00 00828 00 1
00221823 00 00828 03 1
00221804 00 00828 0b 1
0022182b 00 00828 09 1
0022180b 00 01828 01 1
00220018 00 00008 11 1
00001810 00 00828 15 1
00021900 00 00828 0a 1
342200ff 00 02020 05 1
30220f0f 00 02020 04 1
3c021234 00 02020 10 1
2422fffc 00 02028 01 1
38220001 00 02020 06 1
10220004 10 10008 01 1
10220004 00 00008 01 1
14220004 00 10008 01 1
14220004 10 00008 01 1
18200004 01 10008 01 1
18200004 08 00008 01 1
1c200004 0c 10008 01 1
1c200004 03 00008 01 1
04200004 03 10008 01 1
04200004 04 00008 01 1
04210004 04 10008 01 1
04210004 02 00008 01 1
04310004 1c 14028 01 1
04310004 02 04028 01 1
04300004 02 14028 01 1
08000100 00 08008 01 1
0c000100 00 0c028 01 1
03e00008 00 18008 01 1
0020f809 00 1c828 01 1
80220004 00 024f8 01 1
94220004 00 02538 01 1
8c220004 00 02438 01 1
a0220004 00 02288 01 1
a4220004 00 02308 01 1
ac220004 00 02208 01 1
40026000 00 0002c 01 1
40826000 00 0000a 01 1
42000018 00 00009 01 1
42000001 00 00000 01 1
0000000c 00 00000 01 1
70221802 00 00000 01 1
88220004 00 00000 01 1
04220004 1f 00000 01 1
8c220004 00 00000 01 0
00221820 00 00828 00 1

//--- testbench/mipsCtrlTb.sv
module mipsCtrlTb;

  // One stimulus item with its expected ID/EX contents
  typedef struct packed {
    mipsCtrlPkg::instrWord_t instr;
    mipsCtrlPkg::cmpFlags_t  flags;
    logic                    valid;
    mipsCtrlPkg::ctrlWord_t  expCtrl;
    mipsCtrlPkg::aluOp_t     expAluOp;
  } vector_t;

  logic                    clk;
  logic                    arstN;
  logic                    instrValid;
  mipsCtrlPkg::instrWord_t instr;
  mipsCtrlPkg::cmpFlags_t  cmpFlags;
  logic                    ctrlValid;
  mipsCtrlPkg::ctrlWord_t  ctrl;
  mipsCtrlPkg::aluOp_t     aluOp;

  vector_t     vectors[$];
  vector_t     pending;
  logic        havePending;
  int          vecCount;
  logic [31:0] rngState;

  mipsCtrl u_dut (
    .clk        (clk),
    .arstN      (arstN),
    .instrValid (instrValid),
    .instr      (instr),
    .cmpFlags   (cmpFlags),
    .ctrlValid  (ctrlValid),
    .ctrl       (ctrl),
    .aluOp      (aluOp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Numerical Recipes constants
  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic failRun();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic checkCtrl(input mipsCtrlPkg::ctrlWord_t expected,
                           input mipsCtrlPkg::ctrlWord_t actual);
    if (actual !== expected) begin
      $display("mismatch ctrl expected %05h actual %05h at %0t", expected, actual, $time);
      failRun();
    end
  endtask

  task automatic checkAluOp(input mipsCtrlPkg::aluOp_t expected,
                            input mipsCtrlPkg::aluOp_t actual);
    if (actual !== expected) begin
      $display("mismatch aluOp expected %02h actual %02h at %0t", expected, actual, $time);
      failRun();
    end
  endtask

  task automatic checkValid(input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("mismatch ctrlValid expected %h actual %h at %0t", expected, actual, $time);
      failRun();
    end
  endtask

  // Reset and idle state of the ID/EX registers
  task automatic checkCleared();
    checkValid(1'b0, ctrlValid);
    checkCtrl('0, ctrl);
    checkAluOp(mipsCtrlPkg::AluAddu, aluOp);
  endtask

  // Drive one item and check the one driven a cycle earlier
  task automatic runCycle(input vector_t v);
    @(posedge clk);
    instrValid <= v.valid;
    instr <= v.instr;
    cmpFlags <= v.flags;
    @(negedge clk);
    if (havePending) begin
      checkValid(pending.valid, ctrlValid);
      checkCtrl(pending.expCtrl, ctrl);
      checkAluOp(pending.expAluOp, aluOp);
    end
    pending = v;
    havePending = 1'b1;
  endtask

  // Idle slot with random garbage on the instruction bus
  function automatic vector_t idleVector(input logic [31:0] noise);
    vector_t v;
    v.instr = noise;
    v.flags = noise[4:0];
    v.valid = 1'b0;
    v.expCtrl = '0;
    v.expAluOp = mipsCtrlPkg::AluAddu;
    return v;
  endfunction

  task automatic loadVectors();
    int fd;
    int n;
    string line;
    logic [31:0] fInstr;
    logic [31:0] fFlags;
    logic [31:0] fCtrl;
    logic [31:0] fAlu;
    logic [31:0] fValid;
    vector_t v;
    fd = $fopen("testbench/mipsCtrl_input.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open testbench/mipsCtrl_input.txt");
      failRun();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Skip blanks and comment lines
      if ((n > 0) && (line.len() > 1) && (line.getc(0) != "#")) begin
        n = $sscanf(line, "%h %h %h %h %h", fInstr, fFlags, fCtrl, fAlu, fValid);
        if (n != 5) begin
          $display("Error: malformed line in stimulus file: %s", line);
          failRun();
        end
        v.instr = fInstr;
        v.flags = fFlags[4:0];
        v.expCtrl = fCtrl[16:0];
        v.expAluOp = fAlu[4:0];
        v.valid = fValid[0];
        vectors.push_back(v);
      end
    end
    $fclose(fd);
  endtask

  // Watchdog armed once the vector count is known
  initial begin
    wait (vecCount > 0);
    #((vecCount * 4 + 20) * 20);
    $display("Error: simulation did not finish within the expected time");
    failRun();
  end

  // First bound assertion failure ends the run
  initial begin
    wait (u_dut.u_checks.failCount != 0);
    $display("Error: a bound assertion failed at %0t", $time);
    failRun();
  end

  initial begin
    int gaps;
    arstN = 1'b0;
    instrValid = 1'b0;
    instr = '0;
    cmpFlags = '0;
    havePending = 1'b0;
    vecCount = 0;
    rngState = 32'h7848;
    loadVectors();
    if (vectors.size() == 0) begin
      $display("Error: stimulus file holds no vectors");
      failRun();
    end
    vecCount = vectors.size();
    // Three cycles in reset
    repeat (3) begin
      @(negedge clk);
      checkCleared();
    end
    @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    checkCleared();
    foreach (vectors[k]) begin
      runCycle(vectors[k]);
      rngState = nextRandom(rngState);
      gaps = (rngState >> 16) % 3;
      repeat (gaps) begin
        rngState = nextRandom(rngState);
        runCycle(idleVector(rngState));
      end
    end
    // Flush the last item through the register
    rngState = nextRandom(rngState);
    runCycle(idleVector(rngState));
    if (u_dut.u_checks.failCount == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Error: %0d assertion failures", u_dut.u_checks.failCount);
      failRun();
    end
  end

endmodule

//--- testbench/mipsCtrl_assert.sv
module mipsCtrlAssert (
  input logic                   clk,
  input logic                   arstN,
  input logic                   ctrlValid,
  input mipsCtrlPkg::ctrlWord_t ctrl
);

  // Read by the testbench at the end of the run
  int failCount = 0;

  // Registers held clear through reset
  validLowInReset: assert property (@(posedge clk) !arstN |-> !ctrlValid)
    else begin
      $error("ctrlValid high while arstN is low");
      failCount = failCount + 1;
    end

  // A single access direction per instruction
  noReadAndWrite: assert property (@(posedge clk) disable iff (!arstN)
      !(ctrl.memRead && ctrl.memWrite))
    else begin
      $error("memRead and memWrite both set");
      failCount = failCount + 1;
    end

  // Idle slot must not leak strobes
  idleWordZero: assert property (@(posedge clk) disable iff (!arstN)
      !ctrlValid |-> (ctrl == '0))
    else begin
      $error("ctrl not zero while ctrlValid is low");
      failCount = failCount + 1;
    end

  // Exception return writes no register
  eretNoWrite: assert property (@(posedge clk) disable iff (!arstN)
      ctrl.eret |-> !ctrl.regWrite)
    else begin
      $error("eret together with regWrite");
      failCount = failCount + 1;
    end

endmodule

bind mipsCtrl mipsCtrlAssert u_checks (
  .clk       (clk),
  .arstN     (arstN),
  .ctrlValid (ctrlValid),
  .ctrl      (ctrl)
);

//--- source/mipsCtrl.sv
module mipsCtrl (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   instrValid,
  input  mipsCtrlPkg::instrWord_t instr,
  input  mipsCtrlPkg::cmpFlags_t  cmpFlags,
  output logic                   ctrlValid,
  output mipsCtrlPkg::ctrlWord_t  ctrl,
  output mipsCtrlPkg::aluOp_t     aluOp
);

  mipsCtrlPkg::instrClass_t instrClass;
  mipsCtrlPkg::ctrlWord_t   ctrlRaw;
  mipsCtrlPkg::aluOp_t      aluOpRaw;

  // Input side, group flags and branch kind
  opcodeClassifier u_classifier (
    .instr      (instr),
    .instrClass (instrClass)
  );

  // Datapath control bits, branch still unresolved
  controlWordDecoder u_ctrlDecoder (
    .instr      (instr),
    .instrClass (instrClass),
    .ctrlRaw    (ctrlRaw)
  );

  aluOpDecoder u_aluDecoder (
    .instr      (instr),
    .instrClass (instrClass),
    .aluOpRaw   (aluOpRaw)
  );

  // Branch resolution and ID/EX registers
  ctrlOutputStage u_outputStage (
    .clk        (clk),
    .arstN      (arstN),
    .instrValid (instrValid),
    .ctrlRaw    (ctrlRaw),
    .aluOpRaw   (aluOpRaw),
    .branchKind (instrClass.branchKind),
    .cmpFlags   (cmpFlags),
    .ctrlValid  (ctrlValid),
    .ctrl       (ctrl),
    .aluOp      (aluOp)
  );

endmodule

//--- source/ctrlOutputStage.sv
module ctrlOutputStage (
  input  logic                     clk,
  input  logic                     arstN,
  input  logic                     instrValid,
  input  mipsCtrlPkg::ctrlWord_t   ctrlRaw,
  input  mipsCtrlPkg::aluOp_t      aluOpRaw,
  input  mipsCtrlPkg::branchKind_t branchKind,
  input  mipsCtrlPkg::cmpFlags_t   cmpFlags,
  output logic                     ctrlValid,
  output mipsCtrlPkg::ctrlWord_t   ctrl,
  output mipsCtrlPkg::aluOp_t      aluOp
);

  logic taken;
  mipsCtrlPkg::ctrlWord_t ctrlResolved;

  // Pick the comparator flag named by the branch kind
  always_comb begin
    case (branchKind)
      mipsCtrlPkg::Eq:  taken = cmpFlags.eq;
      mipsCtrlPkg::Ne:  taken = !cmpFlags.eq;
      mipsCtrlPkg::Gtz: taken = cmpFlags.gz;
      mipsCtrlPkg::Lez: taken = cmpFlags.lez;
      mipsCtrlPkg::Gez: taken = cmpFlags.gez;
      mipsCtrlPkg::Ltz: taken = cmpFlags.lz;
      default:          taken = 1'b0;
    endcase
  end

  // Not-taken branch falls back to sequential, link bit untouched
  always_comb begin
    ctrlResolved = ctrlRaw;
    if ((ctrlRaw.pcSrc == mipsCtrlPkg::Branch) && !taken) begin
      ctrlResolved.pcSrc = mipsCtrlPkg::Seq;
    end
  end

  // ID/EX boundary
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlValid <= 1'b0;
      ctrl <= '0;
      aluOp <= mipsCtrlPkg::AluAddu;
    end else begin
      ctrlValid <= instrValid;
      // Idle slot carries the no-op word
      ctrl <= instrValid ? ctrlResolved : '0;
      aluOp <= instrValid ? aluOpRaw : mipsCtrlPkg::AluAddu;
    end
  end

endmodule

//--- source/aluOpDecoder.sv
module aluOpDecoder (
  input  mipsCtrlPkg::instrWord_t  instr,
  input  mipsCtrlPkg::instrClass_t instrClass,
  output mipsCtrlPkg::aluOp_t      aluOpRaw
);

  always_comb begin
    // Address adds, links, moves, cp0 and no-ops all use ADDU
    aluOpRaw = mipsCtrlPkg::AluAddu;
    if (instrClass.rType) begin
      case (instr.r.funct)
        mipsCtrlPkg::FnAdd:   aluOpRaw = mipsCtrlPkg::AluAdd;
        mipsCtrlPkg::FnSub:   aluOpRaw = mipsCtrlPkg::AluSub;
        mipsCtrlPkg::FnSubu:  aluOpRaw = mipsCtrlPkg::AluSubu;
        mipsCtrlPkg::FnAnd:   aluOpRaw = mipsCtrlPkg::AluAnd;
        mipsCtrlPkg::FnOr:    aluOpRaw = mipsCtrlPkg::AluOr;
        mipsCtrlPkg::FnXor:   aluOpRaw = mipsCtrlPkg::AluXor;
        mipsCtrlPkg::FnNor:   aluOpRaw = mipsCtrlPkg::AluNor;
        mipsCtrlPkg::FnSlt:   aluOpRaw = mipsCtrlPkg::AluSlt;
        mipsCtrlPkg::FnSltu:  aluOpRaw = mipsCtrlPkg::AluSltu;
        // Shifts, fixed amount and variable
        mipsCtrlPkg::FnSll:   aluOpRaw = mipsCtrlPkg::AluSll;
        mipsCtrlPkg::FnSllv:  aluOpRaw = mipsCtrlPkg::AluSllv;
        mipsCtrlPkg::FnSrl:   aluOpRaw = mipsCtrlPkg::AluSrl;
        mipsCtrlPkg::FnSrlv:  aluOpRaw = mipsCtrlPkg::AluSrlv;
        mipsCtrlPkg::FnSra:   aluOpRaw = mipsCtrlPkg::AluSra;
        mipsCtrlPkg::FnSrav:  aluOpRaw = mipsCtrlPkg::AluSrav;
        // HI/LO unit
        mipsCtrlPkg::FnMult:  aluOpRaw = mipsCtrlPkg::AluMult;
        mipsCtrlPkg::FnMultu: aluOpRaw = mipsCtrlPkg::AluMultu;
        mipsCtrlPkg::FnDiv:   aluOpRaw = mipsCtrlPkg::AluDiv;
        mipsCtrlPkg::FnDivu:  aluOpRaw = mipsCtrlPkg::AluDivu;
        mipsCtrlPkg::FnMfhi:  aluOpRaw = mipsCtrlPkg::AluMfhi;
        mipsCtrlPkg::FnMflo:  aluOpRaw = mipsCtrlPkg::AluMflo;
        mipsCtrlPkg::FnMthi:  aluOpRaw = mipsCtrlPkg::AluMthi;
        mipsCtrlPkg::FnMtlo:  aluOpRaw = mipsCtrlPkg::AluMtlo;
        default:              aluOpRaw = mipsCtrlPkg::AluAddu;
      endcase
    end else if (instrClass.other) begin
      // Immediate ALU group, loads and stores fall to ADDU
      case (instr.i.opcode)
        mipsCtrlPkg::OpAddi:  aluOpRaw = mipsCtrlPkg::AluAdd;
        mipsCtrlPkg::OpSlti:  aluOpRaw = mipsCtrlPkg::AluSlt;
        mipsCtrlPkg::OpSltiu: aluOpRaw = mipsCtrlPkg::AluSltu;
        mipsCtrlPkg::OpAndi:  aluOpRaw = mipsCtrlPkg::AluAnd;
        mipsCtrlPkg::OpOri:   aluOpRaw = mipsCtrlPkg::AluOr;
        mipsCtrlPkg::OpXori:  aluOpRaw = mipsCtrlPkg::AluXor;
        mipsCtrlPkg::OpLui:   aluOpRaw = mipsCtrlPkg::AluSllc;
        default:              aluOpRaw = mipsCtrlPkg::AluAddu;
      endcase
    end
  end

endmodule

//--- source/controlWordDecoder.sv
module controlWordDecoder (
  input  mipsCtrlPkg::instrWord_t  instr,
  input  mipsCtrlPkg::instrClass_t instrClass,
  output mipsCtrlPkg::ctrlWord_t   ctrlRaw
);

  mipsCtrlPkg::ctrlWord_t w;
  logic known;

  always_comb begin
    w = '0;
    known = 1'b0;
    if (instrClass.branchKind != mipsCtrlPkg::None) begin
      // Unresolved here, output stage picks taken or not
      known = 1'b1;
      w.pcSrc = mipsCtrlPkg::Branch;
      // BGEZAL and BLTZAL write $31 either way
      w.link = instrClass.regimm && instr.i.rt[4];
      w.regWrite = w.link;
    end else if (instrClass.rType) begin
      // Default R-type shape, rd written
      w.regDst = 1'b1;
      w.regWrite = 1'b1;
      case (instr.r.funct)
        mipsCtrlPkg::FnJr: begin
          known = 1'b1;
          w.pcSrc = mipsCtrlPkg::JumpReg;
          w.regDst = 1'b0;
          w.regWrite = 1'b0;
        end
        mipsCtrlPkg::FnJalr: begin
          known = 1'b1;
          w.pcSrc = mipsCtrlPkg::JumpReg;
          w.link = 1'b1;
        end
        mipsCtrlPkg::FnMovn, mipsCtrlPkg::FnMovz: begin
          known = 1'b1;
          w.movc = 1'b1;
        end
        // HI/LO writers leave the register file alone
        mipsCtrlPkg::FnMult, mipsCtrlPkg::FnMultu, mipsCtrlPkg::FnDiv, mipsCtrlPkg::FnDivu,
        mipsCtrlPkg::FnMthi, mipsCtrlPkg::FnMtlo: begin
          known = 1'b1;
          w.regDst = 1'b0;
          w.regWrite = 1'b0;
        end
        mipsCtrlPkg::FnSll, mipsCtrlPkg::FnSrl, mipsCtrlPkg::FnSra, mipsCtrlPkg::FnSllv,
        mipsCtrlPkg::FnSrlv, mipsCtrlPkg::FnSrav, mipsCtrlPkg::FnMfhi, mipsCtrlPkg::FnMflo,
        mipsCtrlPkg::FnAdd, mipsCtrlPkg::FnAddu, mipsCtrlPkg::FnSub, mipsCtrlPkg::FnSubu,
        mipsCtrlPkg::FnAnd, mipsCtrlPkg::FnOr, mipsCtrlPkg::FnXor, mipsCtrlPkg::FnNor,
        mipsCtrlPkg::FnSlt, mipsCtrlPkg::FnSltu: known = 1'b1;
        default: known = 1'b0;
      endcase
    end else if (instrClass.cp0) begin
      case (instr.r.rs)
        mipsCtrlPkg::RsMf: begin
          known = 1'b1;
          w.mfc0 = 1'b1;
          w.regWrite = 1'b1;
        end
        mipsCtrlPkg::RsMt: begin
          known = 1'b1;
          w.mtc0 = 1'b1;
        end
        mipsCtrlPkg::RsEret: begin
          // Only the exact ERET funct counts
          known = (instr.r.funct == mipsCtrlPkg::FnEret);
          w.eret = 1'b1;
        end
        default: known = 1'b0;
      endcase
    end else if (instrClass.other) begin
      // Immediate operand for everything but jumps
      w.aluSrcImm = 1'b1;
      known = 1'b1;
      case (instr.i.opcode)
        mipsCtrlPkg::OpJ: begin
          w.aluSrcImm = 1'b0;
          w.pcSrc = mipsCtrlPkg::JumpImm;
        end
        mipsCtrlPkg::OpJal: begin
          w.aluSrcImm = 1'b0;
          w.pcSrc = mipsCtrlPkg::JumpImm;
          w.link = 1'b1;
          w.regWrite = 1'b1;
        end
        mipsCtrlPkg::OpAddi, mipsCtrlPkg::OpAddiu, mipsCtrlPkg::OpSlti, mipsCtrlPkg::OpSltiu,
        mipsCtrlPkg::OpAndi, mipsCtrlPkg::OpOri, mipsCtrlPkg::OpXori,
        mipsCtrlPkg::OpLui: w.regWrite = 1'b1;
        // Loads, size from opcode[1:0], signed when opcode[2] clear
        mipsCtrlPkg::OpLb, mipsCtrlPkg::OpLh, mipsCtrlPkg::OpLw, mipsCtrlPkg::OpLbu,
        mipsCtrlPkg::OpLhu: begin
          w.memRead = 1'b1;
          w.regWrite = 1'b1;
          w.memToReg = 1'b1;
          w.memByte = (instr.i.opcode[1:0] == 2'b00);
          w.memHalf = (instr.i.opcode[1:0] == 2'b01);
          w.memSignExtend = !instr.i.opcode[2] && (instr.i.opcode[1:0] != 2'b11);
        end
        mipsCtrlPkg::OpSb, mipsCtrlPkg::OpSh, mipsCtrlPkg::OpSw: begin
          w.memWrite = 1'b1;
          w.memByte = (instr.i.opcode[1:0] == 2'b00);
          w.memHalf = (instr.i.opcode[1:0] == 2'b01);
        end
        default: known = 1'b0;
      endcase
    end
    // Zero extension only for opcodes 0011xx
    w.signExtend = (instr.i.opcode[5:2] != 4'b0011);
  end

  // Unsupported encodings collapse to the no-op word
  assign ctrlRaw = known ? w : '0;

endmodule

//--- source/opcodeClassifier.sv
module opcodeClassifier (
  input  mipsCtrlPkg::instrWord_t  instr,
  output mipsCtrlPkg::instrClass_t instrClass
);

  logic [5:0] opcode;
  logic [4:0] rt;

  assign opcode = instr.r.opcode;
  // Regimm selector sits in the rt slot of the I layout
  assign rt = instr.i.rt;

  always_comb begin
    // Group flags
    instrClass.rType  = (opcode == mipsCtrlPkg::OpTypeR);
    instrClass.regimm = (opcode == mipsCtrlPkg::OpTypeBI);
    instrClass.cp0    = (opcode == mipsCtrlPkg::OpTypeCP0);
    instrClass.other  = !(instrClass.rType || instrClass.regimm || instrClass.cp0);

    // Branch kind
    instrClass.branchKind = mipsCtrlPkg::None;
    // BEQ, BNE, BLEZ, BGTZ share opcode 0001xx
    if (opcode[5:2] == 4'b0001) begin
      case (opcode[1:0])
        2'b00:   instrClass.branchKind = mipsCtrlPkg::Eq;
        2'b01:   instrClass.branchKind = mipsCtrlPkg::Ne;
        2'b10:   instrClass.branchKind = mipsCtrlPkg::Lez;
        default: instrClass.branchKind = mipsCtrlPkg::Gtz;
      endcase
    end else if (instrClass.regimm && (rt[3:1] == 3'b000)) begin
      // rt[4] is link and rt[0] picks GEZ over LTZ
      if (rt[0]) begin
        instrClass.branchKind = mipsCtrlPkg::Gez;
      end else begin
        instrClass.branchKind = mipsCtrlPkg::Ltz;
      end
    end
  end

endmodule

//--- source/mipsCtrlPkg.sv
package mipsCtrlPkg;

  // Instruction field layouts, MSB first
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rFields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iFields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } jFields_t;

  // One fetched word, three readings
  typedef union packed {
    rFields_t r;
    iFields_t i;
    jFields_t j;
  } instrWord_t;

  // Primary opcodes
  localparam logic [5:0] OpTypeR   = 6'h00;
  localparam logic [5:0] OpTypeBI  = 6'h01;
  localparam logic [5:0] OpJ       = 6'h02;
  localparam logic [5:0] OpJal     = 6'h03;
  localparam logic [5:0] OpAddi    = 6'h08;
  localparam logic [5:0] OpAddiu   = 6'h09;
  localparam logic [5:0] OpSlti    = 6'h0a;
  localparam logic [5:0] OpSltiu   = 6'h0b;
  localparam logic [5:0] OpAndi    = 6'h0c;
  localparam logic [5:0] OpOri     = 6'h0d;
  localparam logic [5:0] OpXori    = 6'h0e;
  localparam logic [5:0] OpLui     = 6'h0f;
  localparam logic [5:0] OpTypeCP0 = 6'h10;
  localparam logic [5:0] OpLb      = 6'h20;
  localparam logic [5:0] OpLh      = 6'h21;
  localparam logic [5:0] OpLw      = 6'h23;
  localparam logic [5:0] OpLbu     = 6'h24;
  localparam logic [5:0] OpLhu     = 6'h25;
  localparam logic [5:0] OpSb      = 6'h28;
  localparam logic [5:0] OpSh      = 6'h29;
  localparam logic [5:0] OpSw      = 6'h2b;

  // SPECIAL functs
  localparam logic [5:0] FnSll   = 6'h00;
  localparam logic [5:0] FnSrl   = 6'h02;
  localparam logic [5:0] FnSra   = 6'h03;
  localparam logic [5:0] FnSllv  = 6'h04;
  localparam logic [5:0] FnSrlv  = 6'h06;
  localparam logic [5:0] FnSrav  = 6'h07;
  localparam logic [5:0] FnJr    = 6'h08;
  localparam logic [5:0] FnJalr  = 6'h09;
  localparam logic [5:0] FnMovz  = 6'h0a;
  localparam logic [5:0] FnMovn  = 6'h0b;
  localparam logic [5:0] FnMfhi  = 6'h10;
  localparam logic [5:0] FnMthi  = 6'h11;
  localparam logic [5:0] FnMflo  = 6'h12;
  localparam logic [5:0] FnMtlo  = 6'h13;
  localparam logic [5:0] FnMult  = 6'h18;
  localparam logic [5:0] FnMultu = 6'h19;
  localparam logic [5:0] FnDiv   = 6'h1a;
  localparam logic [5:0] FnDivu  = 6'h1b;
  localparam logic [5:0] FnAdd   = 6'h20;
  localparam logic [5:0] FnAddu  = 6'h21;
  localparam logic [5:0] FnSub   = 6'h22;
  localparam logic [5:0] FnSubu  = 6'h23;
  localparam logic [5:0] FnAnd   = 6'h24;
  localparam logic [5:0] FnOr    = 6'h25;
  localparam logic [5:0] FnXor   = 6'h26;
  localparam logic [5:0] FnNor   = 6'h27;
  localparam logic [5:0] FnSlt   = 6'h2a;
  localparam logic [5:0] FnSltu  = 6'h2b;
  // ERET funct inside the CP0 group
  localparam logic [5:0] FnEret  = 6'h18;

  // REGIMM rt selectors
  localparam logic [4:0] RtBltz   = 5'h00;
  localparam logic [4:0] RtBgez   = 5'h01;
  localparam logic [4:0] RtBltzal = 5'h10;
  localparam logic [4:0] RtBgezal = 5'h11;

  // CP0 rs selectors
  localparam logic [4:0] RsMf   = 5'h00;
  localparam logic [4:0] RsMt   = 5'h04;
  localparam logic [4:0] RsEret = 5'h10;

  // ALU operation codes
  typedef logic [4:0] aluOp_t;
  localparam aluOp_t AluAdd   = 5'd0;
  localparam aluOp_t AluAddu  = 5'd1;
  localparam aluOp_t AluSub   = 5'd2;
  localparam aluOp_t AluSubu  = 5'd3;
  localparam aluOp_t AluAnd   = 5'd4;
  localparam aluOp_t AluOr    = 5'd5;
  localparam aluOp_t AluXor   = 5'd6;
  localparam aluOp_t AluNor   = 5'd7;
  localparam aluOp_t AluSlt   = 5'd8;
  localparam aluOp_t AluSltu  = 5'd9;
  localparam aluOp_t AluSll   = 5'd10;
  localparam aluOp_t AluSllv  = 5'd11;
  localparam aluOp_t AluSrl   = 5'd12;
  localparam aluOp_t AluSrlv  = 5'd13;
  localparam aluOp_t AluSra   = 5'd14;
  localparam aluOp_t AluSrav  = 5'd15;
  // LUI, immediate shifted left by 16
  localparam aluOp_t AluSllc  = 5'd16;
  localparam aluOp_t AluMult  = 5'd17;
  localparam aluOp_t AluMultu = 5'd18;
  localparam aluOp_t AluDiv   = 5'd19;
  localparam aluOp_t AluDivu  = 5'd20;
  localparam aluOp_t AluMfhi  = 5'd21;
  localparam aluOp_t AluMflo  = 5'd22;
  localparam aluOp_t AluMthi  = 5'd23;
  localparam aluOp_t AluMtlo  = 5'd24;

  typedef enum logic [1:0] {
    Seq     = 2'b00,
    JumpImm = 2'b01,
    Branch  = 2'b10,
    JumpReg = 2'b11
  } pcSrc_t;

  // Decode-stage comparator, rs against rt or zero
  typedef struct packed {
    logic eq;
    logic gz;
    logic gez;
    logic lz;
    logic lez;
  } cmpFlags_t;

  typedef enum logic [2:0] {
    None = 3'd0,
    Eq   = 3'd1,
    Ne   = 3'd2,
    Gtz  = 3'd3,
    Lez  = 3'd4,
    Gez  = 3'd5,
    Ltz  = 3'd6
  } branchKind_t;

  // Exactly one group flag is set
  typedef struct packed {
    logic        rType;
    logic        regimm;
    logic        cp0;
    logic        other;
    branchKind_t branchKind;
  } instrClass_t;

  typedef struct packed {
    pcSrc_t pcSrc;
    logic   link;
    logic   aluSrcImm;
    logic   movc;
    logic   regDst;
    logic   memRead;
    logic   memWrite;
    logic   memHalf;
    logic   memByte;
    logic   memSignExtend;
    logic   regWrite;
    logic   memToReg;
    logic   signExtend;
    logic   mfc0;
    logic   mtc0;
    logic   eret;
  } ctrlWord_t;

endpackage
